// File: logic/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// word address into the bank
`define MEM_ADDR_WIDTH 10

// data word carried by loads and stores
`define MEM_DATA_WIDTH 32

// queue entries
`define MEM_REQ_DEPTH 8
`define MEM_RSP_DEPTH 8

// issue width of the core
`define MEM_SLOTS 2

`endif

// File: logic/mem_types_pkg.sv
`include "mem_consts.svh"

package mem_types_pkg;

    // one bit, load is the zero value
    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_e;

    // request as held in the request queue
    typedef struct packed {
        mem_op_e                      op;
        logic [`MEM_ADDR_WIDTH - 1:0] addr;
        logic [`MEM_DATA_WIDTH - 1:0] data;
    } mem_req_t;

    // response word: loaded data or the echoed store data
    typedef struct packed {
        logic                         is_store;
        logic [`MEM_DATA_WIDTH - 1:0] data;
    } mem_rsp_t;

endpackage

// File: logic/pipe_ctrl_pkg.sv
`include "mem_consts.svh"

package pipe_ctrl_pkg;

    // slot 1 never moves without slot 0, so 2'b10 is illegal
    typedef enum logic [1:0] {
        mask_none  = 2'b00,
        mask_slot0 = 2'b01,
        mask_both  = 2'b11
    } slot_mask_e;

    // occupancy up to the larger queue depth, inclusive
    typedef logic [$clog2(((`MEM_REQ_DEPTH > `MEM_RSP_DEPTH) ? `MEM_REQ_DEPTH
                           : `MEM_RSP_DEPTH) + 1) - 1:0] queue_count_t;

    // number of slots a mask selects
    function automatic logic [1:0] mask_count(slot_mask_e mask);
        case (mask)
            mask_slot0: return 2'd1;
            mask_both:  return 2'd2;
            default:    return 2'd0;
        endcase
    endfunction

    // inverse of mask_count, anything above two saturates
    function automatic slot_mask_e count_to_mask(int unsigned n);
        if (n >= 2)
            return mask_both;
        else if (n == 1)
            return mask_slot0;
        else
            return mask_none;
    endfunction

endpackage

// File: logic/addr_gen.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module addr_gen (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     stall,
    input  logic [`MEM_SLOTS - 1:0]                  issue_valid,
    input  mem_types_pkg::mem_op_e                   issue_op     [`MEM_SLOTS],
    input  logic [`MEM_DATA_WIDTH - 1:0]             issue_base   [`MEM_SLOTS],
    input  logic [`MEM_DATA_WIDTH - 1:0]             issue_offset [`MEM_SLOTS],
    input  logic [`MEM_DATA_WIDTH - 1:0]             issue_wdata  [`MEM_SLOTS],
    output pipe_ctrl_pkg::slot_mask_e                req_enq,
    output mem_types_pkg::mem_req_t                  req_entry    [`MEM_SLOTS]
);

    logic [`MEM_DATA_WIDTH - 1:0] eff_addr [`MEM_SLOTS];

    // full width sum, only the low bits reach the bank
    always_comb begin
        for (int s = 0; s < `MEM_SLOTS; s++) begin
            eff_addr[s] = issue_base[s] + issue_offset[s];
        end
    end

    // enqueue strobe for the next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            req_enq <= pipe_ctrl_pkg::mask_none;
        end else if (stall) begin
            req_enq <= pipe_ctrl_pkg::mask_none;
        end else begin
            req_enq <= pipe_ctrl_pkg::slot_mask_e'(issue_valid);
        end
    end

    // payload is captured every cycle, req_enq says which entries count
    always_ff @(posedge clk) begin
        for (int s = 0; s < `MEM_SLOTS; s++) begin
            req_entry[s].op   <= issue_op[s];
            req_entry[s].addr <= eff_addr[s][`MEM_ADDR_WIDTH - 1:0];
            req_entry[s].data <= issue_wdata[s];
        end
    end

    // program order: a lone slot 1 issue would jump ahead of nothing
    a_issue_order : assert property (
        @(posedge clk) disable iff (rst)
        !stall |-> issue_valid != 2'b10
    ) else $error("addr_gen: slot 1 issued without slot 0");

endmodule

// File: logic/mem_queue.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_queue #(
    parameter type payload_t = mem_types_pkg::mem_req_t,
    parameter int  depth     = `MEM_REQ_DEPTH
) (
    input  logic                         clk,
    input  logic                         rst,
    input  pipe_ctrl_pkg::slot_mask_e    enq,
    input  payload_t                     enq_data   [`MEM_SLOTS],
    input  pipe_ctrl_pkg::slot_mask_e    pop,
    output payload_t                     head       [`MEM_SLOTS],
    output logic [`MEM_SLOTS - 1:0]      head_valid,
    output pipe_ctrl_pkg::queue_count_t  count
);

    localparam int ptr_w = $clog2(depth);

    typedef logic [ptr_w - 1:0] ptr_t;

    payload_t   ram [depth];
    ptr_t       rd_ptr;
    ptr_t       wr_ptr;
    ptr_t       rd_ptr_1;
    ptr_t       wr_ptr_1;
    logic [1:0] enq_n;
    logic [1:0] pop_n;

    // depth is a power of two, pointers wrap on their own
    assign rd_ptr_1 = ptr_t'(rd_ptr + ptr_t'(1));
    assign wr_ptr_1 = ptr_t'(wr_ptr + ptr_t'(1));

    assign enq_n = pipe_ctrl_pkg::mask_count(enq);
    assign pop_n = pipe_ctrl_pkg::mask_count(pop);

    // pointer and occupancy update, enq and pop in one cycle both apply
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= ptr_t'(wr_ptr + ptr_t'(enq_n));
            rd_ptr <= ptr_t'(rd_ptr + ptr_t'(pop_n));
            count  <= pipe_ctrl_pkg::queue_count_t'(count + enq_n - pop_n);
        end
    end

    always_ff @(posedge clk) begin
        if (enq != pipe_ctrl_pkg::mask_none) begin
            ram[wr_ptr] <= enq_data[0];
        end
        if (enq == pipe_ctrl_pkg::mask_both) begin
            ram[wr_ptr_1] <= enq_data[1];
        end
    end

    // heads are always presented, the consumer pops from what it sees
    assign head[0] = ram[rd_ptr];
    assign head[1] = ram[rd_ptr_1];

    assign head_valid[0] = count >= 1;
    assign head_valid[1] = count >= 2;

    a_mask_legal : assert property (
        @(posedge clk) disable iff (rst)
        enq inside {pipe_ctrl_pkg::mask_none, pipe_ctrl_pkg::mask_slot0,
                    pipe_ctrl_pkg::mask_both} &&
        pop inside {pipe_ctrl_pkg::mask_none, pipe_ctrl_pkg::mask_slot0,
                    pipe_ctrl_pkg::mask_both}
    ) else $error("mem_queue: illegal slot mask");

    // producer must respect the space it was told about
    a_no_overflow : assert property (
        @(posedge clk) disable iff (rst)
        int'(count) + int'(enq_n) <= depth
    ) else $error("mem_queue: enqueue beyond free space");

    a_no_underflow : assert property (
        @(posedge clk) disable iff (rst)
        int'(pop_n) <= int'(count)
    ) else $error("mem_queue: pop of an invalid head");

endmodule

// File: logic/dram_bank.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module dram_bank (
    input  logic                         clk,
    input  logic                         rst,
    input  pipe_ctrl_pkg::slot_mask_e    acc,
    input  mem_types_pkg::mem_req_t      acc_req [`MEM_SLOTS],
    output pipe_ctrl_pkg::slot_mask_e    rsp_en,
    output mem_types_pkg::mem_rsp_t      rsp     [`MEM_SLOTS]
);

    localparam int words = 1 << `MEM_ADDR_WIDTH;

    logic [`MEM_DATA_WIDTH - 1:0] mem [words];
    logic [`MEM_DATA_WIDTH - 1:0] rd_data [`MEM_SLOTS];
    logic                         is_st   [`MEM_SLOTS];
    logic                         fwd_1;

    always_comb begin
        for (int s = 0; s < `MEM_SLOTS; s++) begin
            is_st[s] = acc_req[s].op == mem_types_pkg::op_store;
        end
    end

    // slot 1 sees slot 0's store to the same word
    assign fwd_1 = is_st[0] && (acc_req[0].addr == acc_req[1].addr);

    assign rd_data[0] = mem[acc_req[0].addr];
    assign rd_data[1] = fwd_1 ? acc_req[0].data : mem[acc_req[1].addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < words; w++) begin
                mem[w] <= '0;
            end
        end else begin
            if (acc != pipe_ctrl_pkg::mask_none && is_st[0]) begin
                mem[acc_req[0].addr] <= acc_req[0].data;
            end
            // later write wins when both slots store to one word
            if (acc == pipe_ctrl_pkg::mask_both && is_st[1]) begin
                mem[acc_req[1].addr] <= acc_req[1].data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_en <= pipe_ctrl_pkg::mask_none;
        end else begin
            rsp_en <= acc;
        end
    end

    // store responses echo the written word
    always_ff @(posedge clk) begin
        for (int s = 0; s < `MEM_SLOTS; s++) begin
            rsp[s].is_store <= is_st[s];
            rsp[s].data     <= is_st[s] ? acc_req[s].data : rd_data[s];
        end
    end

endmodule

// File: logic/issue_ctrl.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module issue_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  pipe_ctrl_pkg::queue_count_t  req_count,
    input  logic [`MEM_SLOTS - 1:0]      req_head_valid,
    input  pipe_ctrl_pkg::queue_count_t  rsp_count,
    input  pipe_ctrl_pkg::slot_mask_e    bank_rsp_en,
    output pipe_ctrl_pkg::slot_mask_e    req_pop,
    output logic                         issue_stall
);

    // two slots may sit in addr_gen plus two more issued behind them
    localparam int stall_margin = 2 * `MEM_SLOTS;

    int unsigned heads_ready;
    int unsigned in_flight;
    int unsigned rsp_space;
    int unsigned retire_n;

    always_comb begin
        if (req_head_valid[1]) begin
            heads_ready = 2;
        end else if (req_head_valid[0]) begin
            heads_ready = 1;
        end else begin
            heads_ready = 0;
        end
    end

    // bank responses land in the response queue at the next edge
    assign in_flight = pipe_ctrl_pkg::mask_count(bank_rsp_en);

    always_comb begin
        if (int'(rsp_count) + int'(in_flight) >= `MEM_RSP_DEPTH) begin
            rsp_space = 0;
        end else begin
            rsp_space = `MEM_RSP_DEPTH - rsp_count - in_flight;
        end
    end

    assign retire_n = (heads_ready < rsp_space) ? heads_ready : rsp_space;
    assign req_pop  = pipe_ctrl_pkg::count_to_mask(retire_n);

    // stall ignores pops of this cycle
    assign issue_stall = (`MEM_REQ_DEPTH - int'(req_count)) < stall_margin;

    a_pop_valid : assert property (
        @(posedge clk) disable iff (rst)
        int'(pipe_ctrl_pkg::mask_count(req_pop)) <= int'(req_count)
    ) else $error("issue_ctrl: retire selects an empty head");

endmodule

// File: logic/mem_pipe_top.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_pipe_top (
    input  logic                         clk,
    input  logic                         rst,

    // issue side, slot 0 is the older operation
    input  logic [`MEM_SLOTS - 1:0]      issue_valid,
    input  mem_types_pkg::mem_op_e       issue_op     [`MEM_SLOTS],
    input  logic [`MEM_DATA_WIDTH - 1:0] issue_base   [`MEM_SLOTS],
    input  logic [`MEM_DATA_WIDTH - 1:0] issue_offset [`MEM_SLOTS],
    input  logic [`MEM_DATA_WIDTH - 1:0] issue_wdata  [`MEM_SLOTS],
    output logic                         issue_stall,

    // response side
    output logic [`MEM_SLOTS - 1:0]      rsp_valid,
    output logic [`MEM_DATA_WIDTH - 1:0] rsp_data     [`MEM_SLOTS],
    output logic [`MEM_SLOTS - 1:0]      rsp_is_store,
    input  pipe_ctrl_pkg::slot_mask_e    rsp_pop
);

    pipe_ctrl_pkg::slot_mask_e    req_enq;
    mem_types_pkg::mem_req_t      req_entry      [`MEM_SLOTS];
    mem_types_pkg::mem_req_t      req_head       [`MEM_SLOTS];
    logic [`MEM_SLOTS - 1:0]      req_head_valid;
    pipe_ctrl_pkg::queue_count_t  req_count;
    pipe_ctrl_pkg::slot_mask_e    req_pop;

    pipe_ctrl_pkg::slot_mask_e    bank_rsp_en;
    mem_types_pkg::mem_rsp_t      bank_rsp       [`MEM_SLOTS];
    mem_types_pkg::mem_rsp_t      rsp_head       [`MEM_SLOTS];
    pipe_ctrl_pkg::queue_count_t  rsp_count;

    addr_gen addr_gen_i (
        .clk          (clk),
        .rst          (rst),
        .stall        (issue_stall),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_base   (issue_base),
        .issue_offset (issue_offset),
        .issue_wdata  (issue_wdata),
        .req_enq      (req_enq),
        .req_entry    (req_entry)
    );

    mem_queue #(
        .payload_t (mem_types_pkg::mem_req_t),
        .depth     (`MEM_REQ_DEPTH)
    ) req_queue_i (
        .clk        (clk),
        .rst        (rst),
        .enq        (req_enq),
        .enq_data   (req_entry),
        .pop        (req_pop),
        .head       (req_head),
        .head_valid (req_head_valid),
        .count      (req_count)
    );

    issue_ctrl issue_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .req_count      (req_count),
        .req_head_valid (req_head_valid),
        .rsp_count      (rsp_count),
        .bank_rsp_en    (bank_rsp_en),
        .req_pop        (req_pop),
        .issue_stall    (issue_stall)
    );

    // retired heads are the bank accesses of this cycle
    dram_bank dram_bank_i (
        .clk     (clk),
        .rst     (rst),
        .acc     (req_pop),
        .acc_req (req_head),
        .rsp_en  (bank_rsp_en),
        .rsp     (bank_rsp)
    );

    mem_queue #(
        .payload_t (mem_types_pkg::mem_rsp_t),
        .depth     (`MEM_RSP_DEPTH)
    ) rsp_queue_i (
        .clk        (clk),
        .rst        (rst),
        .enq        (bank_rsp_en),
        .enq_data   (bank_rsp),
        .pop        (rsp_pop),
        .head       (rsp_head),
        .head_valid (rsp_valid),
        .count      (rsp_count)
    );

    always_comb begin
        for (int s = 0; s < `MEM_SLOTS; s++) begin
            rsp_data[s]     = rsp_head[s].data;
            rsp_is_store[s] = rsp_head[s].is_store;
        end
    end

endmodule

// File: dv/mem_pipe_checker.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_pipe_checker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`MEM_SLOTS - 1:0]      issue_valid,
    input  mem_types_pkg::mem_op_e       issue_op     [`MEM_SLOTS],
    input  logic [`MEM_DATA_WIDTH - 1:0] issue_base   [`MEM_SLOTS],
    input  logic [`MEM_DATA_WIDTH - 1:0] issue_offset [`MEM_SLOTS],
    input  logic [`MEM_DATA_WIDTH - 1:0] issue_wdata  [`MEM_SLOTS],
    input  logic                         issue_stall,
    input  logic [`MEM_SLOTS - 1:0]      rsp_valid,
    input  logic [`MEM_DATA_WIDTH - 1:0] rsp_data     [`MEM_SLOTS],
    input  logic [`MEM_SLOTS - 1:0]      rsp_is_store,
    input  pipe_ctrl_pkg::slot_mask_e    rsp_pop,
    output int                           error_count,
    output int                           issue_count,
    output int                           answer_count,
    output int                           pending
);

    logic [`MEM_DATA_WIDTH - 1:0] model [1 << `MEM_ADDR_WIDTH];
    // {is_store, data} per outstanding operation, oldest first
    logic [`MEM_DATA_WIDTH:0]     expected [$];

    initial begin
        error_count  = 0;
        issue_count  = 0;
        answer_count = 0;
        pending      = 0;
    end

    // one operation against the model, in program order
    task automatic apply_op(input int s);
        logic [`MEM_DATA_WIDTH - 1:0] sum;
        logic [`MEM_ADDR_WIDTH - 1:0] a;
        sum = issue_base[s] + issue_offset[s];
        a   = sum[`MEM_ADDR_WIDTH - 1:0];
        if (issue_op[s] == mem_types_pkg::op_store) begin
            model[a] = issue_wdata[s];
            expected.push_back({1'b1, issue_wdata[s]});
        end else begin
            expected.push_back({1'b0, model[a]});
        end
        issue_count++;
    endtask

    task automatic check_pop(input int s);
        logic [`MEM_DATA_WIDTH:0] want;
        if (!rsp_valid[s]) begin
            $display("t=%0t: response slot %0d popped while not valid", $time, s);
            error_count++;
        end
        if (expected.size() == 0) begin
            $display("t=%0t: response popped with no operation outstanding", $time);
            error_count++;
        end else begin
            want = expected.pop_front();
            answer_count++;
            if (rsp_is_store[s] !== want[`MEM_DATA_WIDTH]) begin
                $display("ERROR t=%0t rsp_is_store[%0d]: expected %b, got %b",
                         $time, s, want[`MEM_DATA_WIDTH], rsp_is_store[s]);
                error_count++;
            end
            if (rsp_data[s] !== want[`MEM_DATA_WIDTH - 1:0]) begin
                $display("ERROR t=%0t rsp_data[%0d]: expected %h, got %h",
                         $time, s, want[`MEM_DATA_WIDTH - 1:0], rsp_data[s]);
                error_count++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            // reset clears the bank, so the model restarts at zero
            expected.delete();
            for (int w = 0; w < (1 << `MEM_ADDR_WIDTH); w++) begin
                model[w] = '0;
            end
        end else begin
            if (rsp_pop != pipe_ctrl_pkg::mask_none) begin
                check_pop(0);
            end
            if (rsp_pop == pipe_ctrl_pkg::mask_both) begin
                check_pop(1);
            end
            // an issue counts only on an edge with stall low
            if (!issue_stall && issue_valid[0]) begin
                apply_op(0);
            end
            if (!issue_stall && issue_valid[1]) begin
                apply_op(1);
            end
        end
        pending = expected.size();
    end

endmodule

// File: dv/mem_pipe_tb.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_pipe_tb;

    localparam int reset_cycles  = 16;
    localparam int random_cycles = 200;
    localparam int bp_cycles     = 40;
    localparam int drain_limit   = 200;
    // at most two operations per offered cycle, summed over all tests
    localparam int max_ops     = 8 + 6 + 2 * random_cycles + 2 * bp_cycles + 40 + 16;
    localparam int cycle_limit = 10 * max_ops + 2 * reset_cycles;

    localparam mem_types_pkg::mem_op_e ld = mem_types_pkg::op_load;
    localparam mem_types_pkg::mem_op_e st = mem_types_pkg::op_store;

    logic                         clk;
    logic                         rst;
    logic [`MEM_SLOTS - 1:0]      issue_valid;
    mem_types_pkg::mem_op_e       issue_op     [`MEM_SLOTS];
    logic [`MEM_DATA_WIDTH - 1:0] issue_base   [`MEM_SLOTS];
    logic [`MEM_DATA_WIDTH - 1:0] issue_offset [`MEM_SLOTS];
    logic [`MEM_DATA_WIDTH - 1:0] issue_wdata  [`MEM_SLOTS];
    logic                         issue_stall;
    logic [`MEM_SLOTS - 1:0]      rsp_valid;
    logic [`MEM_DATA_WIDTH - 1:0] rsp_data     [`MEM_SLOTS];
    logic [`MEM_SLOTS - 1:0]      rsp_is_store;
    pipe_ctrl_pkg::slot_mask_e    rsp_pop;
    logic [1:0]                   pop_now;
    int error_count;
    int issue_count;
    int answer_count;
    int pending;
    int seed      = 84296;
    // separate stream for the pop side
    int pop_seed  = 84297;
    int pop_mode  = 2;
    int tb_errors = 0;
    int test_base = 0;
    int cycles    = 0;
    logic saw_stall;

    mem_pipe_top mem_pipe_top_i (.*);
    mem_pipe_checker checker_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // pop mode 0 holds, 1 pops at random, 2 pops all it safely can
    always @(posedge clk) begin
        int avail;
        int take;
        logic [1:0] next_pop;
        avail = int'(rsp_valid[0]) + int'(rsp_valid[1]) - int'(pop_now[0]) - int'(pop_now[1]);
        take  = 0;
        if (!rst && avail > 0 && pop_mode == 2) begin
            take = avail;
        end else if (!rst && avail > 0 && pop_mode == 1) begin
            take = {$random(pop_seed)} % (avail + 1);
        end
        next_pop = (take == 2) ? 2'b11 : (take == 1) ? 2'b01 : 2'b00;
        pop_now <= next_pop;
        rsp_pop <= pipe_ctrl_pkg::slot_mask_e'(next_pop);
    end

    task drive_slot(input int s, input mem_types_pkg::mem_op_e op,
                    input logic [31:0] base, input logic [31:0] offset,
                    input logic [31:0] wdata);
        issue_op[s]     <= op;
        issue_base[s]   <= base;
        issue_offset[s] <= offset;
        issue_wdata[s]  <= wdata;
    endtask

    // held until an edge with stall low takes it
    task send_pair(input logic [1:0] v, input mem_types_pkg::mem_op_e op0,
                   input logic [31:0] a0, input logic [31:0] d0,
                   input mem_types_pkg::mem_op_e op1, input logic [31:0] a1,
                   input logic [31:0] d1);
        int guard;
        drive_slot(0, op0, a0, 32'd0, d0);
        drive_slot(1, op1, a1, 32'd0, d1);
        issue_valid <= v;
        guard = 0;
        do begin
            @(posedge clk);
            guard++;
        end while (issue_stall && guard < drain_limit);
        if (issue_stall) begin
            $display("issue pair never accepted, stall stayed high");
            tb_errors++;
        end
        issue_valid <= 2'b00;
    endtask

    // 16 words, with bit 10 sometimes set to check address wrap
    task random_slot(input int s);
        drive_slot(s, ($random(seed) & 1) ? st : ld,
                   ({$random(seed)} % 16) | (($random(seed) & 1) << 10),
                   {$random(seed)} % 8, $random(seed));
    endtask

    task random_offer();
        int r;
        r = {$random(seed)} % 4;
        random_slot(0);
        random_slot(1);
        issue_valid <= (r == 0) ? 2'b00 : (r == 1) ? 2'b01 : 2'b11;
        @(posedge clk);
    endtask

    // returns at a falling edge, once nothing is outstanding
    task wait_drained();
        int n;
        issue_valid <= 2'b00;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (n < drain_limit && (pending != 0 || rsp_valid != 2'b00));
        if (n >= drain_limit) begin
            $display("%0d operations still unanswered after the drain", pending);
            tb_errors++;
        end
    endtask

    task check_all_answered();
        if (answer_count != issue_count) begin
            $display("answered %0d of %0d operations", answer_count, issue_count);
            tb_errors++;
        end
    endtask

    task end_test(input string name);
        $display("%s: %0d errors", name, error_count + tb_errors - test_base);
        test_base = error_count + tb_errors;
        @(posedge clk);
    endtask

    initial begin
        rst         = 1'b1;
        issue_valid = 2'b00;
        rsp_pop     = pipe_ctrl_pkg::mask_none;
        pop_now     = 2'b00;
        for (int s = 0; s < `MEM_SLOTS; s++) begin
            issue_op[s]     = ld;
            issue_base[s]   = '0;
            issue_offset[s] = '0;
            issue_wdata[s]  = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        // loads read zero, the stores in slot 1 tell the responses apart
        for (int i = 0; i < 4; i++) begin
            send_pair(2'b11, ld, i * 2, 32'd0, st, i * 2 + 1, 32'h100 + i);
        end
        wait_drained();
        end_test("test 1 loads after reset");

        // slot 1 sees slot 0's store, and the later of two stores wins
        send_pair(2'b11, st, 32'h20, 32'hcafe_0001, ld, 32'h20, 32'd0);
        send_pair(2'b11, st, 32'h21, 32'h1111_1111, st, 32'h21, 32'h2222_2222);
        send_pair(2'b01, ld, 32'h21, 32'd0, ld, 32'd0, 32'd0);
        wait_drained();
        end_test("test 2 same pair ordering");

        pop_mode <= 1;
        repeat (random_cycles) random_offer();
        pop_mode <= 2;
        wait_drained();
        check_all_answered();
        end_test("test 3 random stream");

        pop_mode <= 0;
        saw_stall = 1'b0;
        for (int i = 0; i < bp_cycles && !saw_stall; i++) begin
            random_offer();
            saw_stall = issue_stall;
        end
        if (!saw_stall) begin
            $display("issue_stall never rose while pops were held back");
            tb_errors++;
        end
        pop_mode <= 2;
        wait_drained();
        check_all_answered();
        end_test("test 4 back-pressure");

        pop_mode <= 1;
        repeat (20) random_offer();
        issue_valid <= 2'b00;
        rst <= 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (rsp_valid != 2'b00 || issue_stall) begin
            $display("pipe not empty after reset");
            tb_errors++;
        end
        @(posedge clk);
        // the words stored above must read back as zero
        for (int i = 0; i < 8; i++) begin
            send_pair(2'b11, ld, i * 2, 32'd0, ld, i * 2 + 1, 32'd0);
        end
        wait_drained();
        end_test("test 5 reset mid-run");

        @(negedge clk);
        $display("issued %0d, answered %0d, errors %0d",
                 issue_count, answer_count, error_count + tb_errors);
        if (error_count + tb_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+logic
logic/mem_types_pkg.sv
logic/pipe_ctrl_pkg.sv
logic/addr_gen.sv
logic/mem_queue.sv
logic/dram_bank.sv
logic/issue_ctrl.sv
logic/mem_pipe_top.sv
dv/mem_pipe_checker.sv
dv/mem_pipe_tb.sv
